// File: common/uart_ctrl_pkg.sv
// ------------------------------------------------------------------------
// Shared definitions of the UART configuration controller: clock and
// timeout constants, SYN and acknowledgement characters, packet ids,
// field encodings, the standard setting and the received-word union
// ------------------------------------------------------------------------

package uart_ctrl_pkg;

  // System clock frequency in Hz
  localparam logic [31:0] CLK_FREQ_HZ = 32'd10_000_000;

  // Number of clock cycles in 50 ms
  localparam logic [31:0] DEFAULT_TIMEOUT = CLK_FREQ_HZ / 20;

  // Request bursts sent by a master before the configuration is given up
  localparam logic [1:0] MAX_ATTEMPTS = 2'd3;

  // SYN characters in one request burst
  localparam logic [1:0] SYN_COUNT = 2'd3;

  // ------------------------------------------------------------------------
  // Characters and packet ids
  // ------------------------------------------------------------------------

  localparam logic [7:0] SYN_CHAR  = 8'h16;

  // The id part of the acknowledgement (6'b000001) is not a configuration id
  localparam logic [7:0] ACKN_CHAR = 8'h06;

  localparam logic [5:0] DATA_WIDTH_ID  = 6'b110001;
  localparam logic [5:0] PARITY_MODE_ID = 6'b110010;
  localparam logic [5:0] STOP_BITS_ID   = 6'b110100;
  localparam logic [5:0] END_CONFIG_ID  = 6'b111000;

  // Data width field
  localparam logic [1:0] DW_5BIT = 2'b00;
  localparam logic [1:0] DW_6BIT = 2'b01;
  localparam logic [1:0] DW_7BIT = 2'b10;
  localparam logic [1:0] DW_8BIT = 2'b11;

  // Parity mode field, both upper codes disable the check
  localparam logic [1:0] PM_EVEN   = 2'b00;
  localparam logic [1:0] PM_ODD    = 2'b01;
  localparam logic [1:0] PM_NONE_A = 2'b10;
  localparam logic [1:0] PM_NONE_B = 2'b11;

  // Standard setting: 8 data bits, even parity, one stop bit, full duplex
  localparam logic [1:0] STD_DATA_WIDTH  = DW_8BIT;
  localparam logic [1:0] STD_PARITY_MODE = PM_EVEN;
  localparam logic [1:0] STD_STOP_BITS   = 2'b00;
  localparam logic [1:0] STD_COMM_MODE   = 2'b11;

  // A received byte is either plain data or a configuration packet
  // with the id in the upper six bits and the option in the lower two
  typedef union packed {
    logic [7:0] raw;
    struct packed {
      logic [5:0] id;
      logic [1:0] option;
    } packet;
  } rx_word_u;

endpackage

// File: rtl/parity_checker.sv
// ------------------------------------------------------------------------
// Parity checker of received words with a one-cycle error pulse on
// each new mismatch
// ------------------------------------------------------------------------

`timescale 1ns/10ps

module parity_checker (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  uart_ctrl_pkg::rx_word_u rx_word_i,
  input  logic                    parity_bit_i,
  input  logic [1:0]              data_width_i,
  input  logic [1:0]              parity_mode_i,
  output logic                    parity_error_o
);

  import uart_ctrl_pkg::*;

  logic data_xor;
  logic mismatch;
  logic mismatch_q;

  // Only the bits that belong to the configured width enter the XOR
  always_comb begin
    case (data_width_i)
      DW_5BIT: data_xor = ^rx_word_i.raw[4:0];
      DW_6BIT: data_xor = ^rx_word_i.raw[5:0];
      DW_7BIT: data_xor = ^rx_word_i.raw[6:0];
      default: data_xor = ^rx_word_i.raw;
    endcase
  end

  // Odd parity expects the inverted XOR on the line
  always_comb begin
    case (parity_mode_i)
      PM_EVEN:   mismatch = (parity_bit_i != data_xor);
      PM_ODD:    mismatch = (parity_bit_i != ~data_xor);
      PM_NONE_A,
      PM_NONE_B: mismatch = 1'b0;
      default:   mismatch = 1'b0;
    endcase
  end

  // The pulse follows the rising edge of the mismatch by one cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mismatch_q     <= 1'b0;
      parity_error_o <= 1'b0;
    end else begin
      mismatch_q     <= mismatch;
      parity_error_o <= mismatch && !mismatch_q;
    end
  end

endmodule

// File: cfg/cfg_timer.sv
// ------------------------------------------------------------------------
// Configuration timer: cycle counter for acknowledgement timeouts and
// counter of master request attempts
// ------------------------------------------------------------------------

`timescale 1ns/10ps

module cfg_timer #(
  parameter logic [31:0] TIMEOUT_CYCLES = uart_ctrl_pkg::DEFAULT_TIMEOUT
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic timer_run_i,
  input  logic attempt_inc_i,
  input  logic attempt_clr_i,
  output logic timeout_o,
  output logic attempts_spent_o
);

  import uart_ctrl_pkg::*;

  localparam int unsigned CNT_W = $clog2(TIMEOUT_CYCLES + 1);

  logic [CNT_W-1:0] count_q;
  logic [1:0]       attempts_q;

  // Counts while the FSM waits, holds at the limit and clears in any other state
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || !timer_run_i) begin
      count_q <= '0;
    end else if (!timeout_o) begin
      count_q <= count_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || attempt_clr_i) begin
      attempts_q <= 2'd0;
    end else if (attempt_inc_i) begin
      attempts_q <= attempts_q + 2'd1;
    end
  end

  assign timeout_o        = (count_q == CNT_W'(TIMEOUT_CYCLES));
  assign attempts_spent_o = (attempts_q == MAX_ATTEMPTS);

endmodule

// File: cfg/cfg_fsm.sv
// ------------------------------------------------------------------------
// Configuration FSM of the UART controller: CPU pass-through in MAIN,
// standard setup, master SYN burst and packet exchange, slave packet
// decoding with acknowledgement
// ------------------------------------------------------------------------

`timescale 1ns/10ps

module cfg_fsm (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  // Receive FIFO head
  input  logic                    rx_valid_i,
  input  uart_ctrl_pkg::rx_word_u rx_word_i,
  output logic                    rx_read_o,
  // Transmit FIFO push
  input  logic                    tx_done_i,
  output logic                    tx_write_o,
  output logic [7:0]              tx_data_o,
  // CPU side
  input  logic                    cpu_rx_read_i,
  input  logic                    cpu_tx_write_i,
  input  logic [7:0]              cpu_tx_data_i,
  input  logic                    cfg_req_mst_i,
  input  logic                    cfg_req_slv_i,
  input  logic                    enable_cfg_receive_i,
  input  logic                    set_std_config_i,
  input  logic [1:0]              data_width_i,
  input  logic [1:0]              parity_mode_i,
  input  logic [1:0]              stop_bits_i,
  input  logic [1:0]              comm_mode_i,
  // Configuration towards the outside registers
  output logic [1:0]              data_width_o,
  output logic [1:0]              parity_mode_o,
  output logic [1:0]              stop_bits_o,
  output logic [1:0]              comm_mode_o,
  output logic                    cfg_store_o,
  output logic                    config_done_o,
  output logic                    config_error_o,
  // Timer interface
  input  logic                    timeout_i,
  input  logic                    attempts_spent_i,
  output logic                    timer_run_o,
  output logic                    attempt_inc_o,
  output logic                    attempt_clr_o
);

  import uart_ctrl_pkg::*;

  localparam logic [3:0] S_MAIN          = 4'd0;
  localparam logic [3:0] S_STD_CONFIG    = 4'd1;
  localparam logic [3:0] S_SYN_BURST     = 4'd2;
  localparam logic [3:0] S_WAIT_REQ_ACKN = 4'd3;
  localparam logic [3:0] S_SEND_PKT      = 4'd4;
  localparam logic [3:0] S_WAIT_TX_MST   = 4'd5;
  localparam logic [3:0] S_WAIT_ACKN_MST = 4'd6;
  localparam logic [3:0] S_SETUP_SLV     = 4'd7;
  localparam logic [3:0] S_SEND_ACKN_SLV = 4'd8;
  localparam logic [3:0] S_WAIT_TX_SLV   = 4'd9;

  // Packet order of the master, the slave only uses FLD_END as a marker
  localparam logic [1:0] FLD_DW  = 2'd0;
  localparam logic [1:0] FLD_PM  = 2'd1;
  localparam logic [1:0] FLD_SB  = 2'd2;
  localparam logic [1:0] FLD_END = 2'd3;

  logic [3:0] state_q, state_d;
  logic [1:0] field_q, field_d;
  logic [1:0] syn_cnt_q, syn_cnt_d;
  logic       ackn_rx;
  rx_word_u   tx_pkt;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q   <= S_MAIN;
      field_q   <= FLD_DW;
      syn_cnt_q <= 2'd0;
    end else begin
      state_q   <= state_d;
      field_q   <= field_d;
      syn_cnt_q <= syn_cnt_d;
    end
  end

  // An acknowledgement counts only when the FIFO really holds a word
  assign ackn_rx = rx_valid_i && (rx_word_i.raw == ACKN_CHAR);

  // Outgoing master packet for the current field
  always_comb begin
    case (field_q)
      FLD_DW:  tx_pkt.packet = '{id: DATA_WIDTH_ID,  option: data_width_i};
      FLD_PM:  tx_pkt.packet = '{id: PARITY_MODE_ID, option: parity_mode_i};
      FLD_SB:  tx_pkt.packet = '{id: STOP_BITS_ID,   option: stop_bits_i};
      default: tx_pkt.packet = '{id: END_CONFIG_ID,  option: 2'b00};
    endcase
  end

  assign config_done_o = (state_q == S_MAIN);

  always_comb begin
    // Outside MAIN the CPU strobes are blocked and the config passes through
    state_d        = state_q;
    field_d        = field_q;
    syn_cnt_d      = 2'd0;
    rx_read_o      = 1'b0;
    tx_write_o     = 1'b0;
    tx_data_o      = cpu_tx_data_i;
    data_width_o   = data_width_i;
    parity_mode_o  = parity_mode_i;
    stop_bits_o    = stop_bits_i;
    comm_mode_o    = comm_mode_i;
    cfg_store_o    = 1'b0;
    config_error_o = 1'b0;
    timer_run_o    = 1'b0;
    attempt_inc_o  = 1'b0;
    attempt_clr_o  = 1'b0;

    case (state_q)
      S_MAIN: begin
        field_d    = FLD_DW;
        rx_read_o  = cpu_rx_read_i;
        tx_write_o = cpu_tx_write_i;
        // A request from the peer wins over a local one
        if (cfg_req_slv_i && enable_cfg_receive_i) begin
          state_d = S_SEND_ACKN_SLV;
        end else if (cfg_req_mst_i) begin
          attempt_clr_o = 1'b1;
          state_d       = S_SYN_BURST;
        end else if (set_std_config_i) begin
          state_d = S_STD_CONFIG;
        end
      end

      S_STD_CONFIG: begin
        cfg_store_o   = 1'b1;
        data_width_o  = STD_DATA_WIDTH;
        parity_mode_o = STD_PARITY_MODE;
        stop_bits_o   = STD_STOP_BITS;
        comm_mode_o   = STD_COMM_MODE;
        state_d       = S_MAIN;
      end

      // One SYN per cycle, the first one of a burst counts as an attempt
      S_SYN_BURST: begin
        tx_write_o    = 1'b1;
        tx_data_o     = SYN_CHAR;
        attempt_inc_o = (syn_cnt_q == 2'd0);
        syn_cnt_d     = syn_cnt_q + 2'd1;
        if (syn_cnt_q == SYN_COUNT - 2'd1) begin
          syn_cnt_d = 2'd0;
          state_d   = S_WAIT_REQ_ACKN;
        end
      end

      // Words other than the acknowledgement are popped and dropped
      S_WAIT_REQ_ACKN: begin
        timer_run_o = 1'b1;
        rx_read_o   = rx_valid_i;
        if (timeout_i) begin
          if (attempts_spent_i) begin
            config_error_o = 1'b1;
            state_d        = S_STD_CONFIG;
          end else begin
            state_d = S_SYN_BURST;
          end
        end else if (ackn_rx) begin
          state_d = S_SEND_PKT;
        end
      end

      S_SEND_PKT: begin
        tx_write_o = 1'b1;
        tx_data_o  = tx_pkt.raw;
        state_d    = S_WAIT_TX_MST;
      end

      // No limit here, the transmitter applies back-pressure
      S_WAIT_TX_MST: begin
        if (tx_done_i) begin
          state_d = S_WAIT_ACKN_MST;
        end
      end

      S_WAIT_ACKN_MST: begin
        timer_run_o = 1'b1;
        rx_read_o   = rx_valid_i;
        if (timeout_i) begin
          config_error_o = 1'b1;
          state_d        = S_STD_CONFIG;
        end else if (ackn_rx) begin
          if (field_q == FLD_END) begin
            state_d = S_MAIN;
          end else begin
            field_d = field_q + 2'd1;
            state_d = S_SEND_PKT;
          end
        end
      end

      // Field packets are stored at once, unknown ids are ignored
      S_SETUP_SLV: begin
        timer_run_o = 1'b1;
        rx_read_o   = rx_valid_i;
        if (timeout_i) begin
          config_error_o = 1'b1;
          state_d        = S_STD_CONFIG;
        end else if (rx_valid_i) begin
          case (rx_word_i.packet.id)
            DATA_WIDTH_ID: begin
              data_width_o = rx_word_i.packet.option;
              cfg_store_o  = 1'b1;
              state_d      = S_SEND_ACKN_SLV;
            end
            PARITY_MODE_ID: begin
              parity_mode_o = rx_word_i.packet.option;
              cfg_store_o   = 1'b1;
              state_d       = S_SEND_ACKN_SLV;
            end
            STOP_BITS_ID: begin
              stop_bits_o = rx_word_i.packet.option;
              cfg_store_o = 1'b1;
              state_d     = S_SEND_ACKN_SLV;
            end
            END_CONFIG_ID: begin
              field_d = FLD_END;
              state_d = S_SEND_ACKN_SLV;
            end
            default: begin
              state_d = S_SETUP_SLV;
            end
          endcase
        end
      end

      S_SEND_ACKN_SLV: begin
        tx_write_o = 1'b1;
        tx_data_o  = ACKN_CHAR;
        state_d    = S_WAIT_TX_SLV;
      end

      // Return to MAIN once the acknowledgement of the end packet has left
      S_WAIT_TX_SLV: begin
        if (tx_done_i) begin
          state_d = (field_q == FLD_END) ? S_MAIN : S_SETUP_SLV;
        end
      end

      default: begin
        state_d = S_MAIN;
      end
    endcase
  end

endmodule

// File: rtl/uart_ctrl_top.sv
// ------------------------------------------------------------------------
// Top level of the UART configuration controller: configuration FSM,
// timeout timer, parity checker and the transmit/receive enables
// ------------------------------------------------------------------------

`timescale 1ns/10ps

module uart_ctrl_top #(
  parameter logic [31:0] TIMEOUT_CYCLES = uart_ctrl_pkg::DEFAULT_TIMEOUT
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  // Receive FIFO
  input  logic                    rx_valid_i,
  input  uart_ctrl_pkg::rx_word_u rx_word_i,
  input  logic                    parity_bit_i,
  output logic                    rx_read_o,
  // Transmit FIFO
  input  logic                    tx_done_i,
  output logic                    tx_write_o,
  output logic [7:0]              tx_data_o,
  // CPU
  input  logic                    cpu_rx_read_i,
  input  logic                    cpu_tx_write_i,
  input  logic [7:0]              cpu_tx_data_i,
  input  logic                    cfg_req_mst_i,
  input  logic                    cfg_req_slv_i,
  input  logic                    enable_cfg_receive_i,
  input  logic                    set_std_config_i,
  input  logic [1:0]              data_width_i,
  input  logic [1:0]              parity_mode_i,
  input  logic [1:0]              stop_bits_i,
  input  logic [1:0]              comm_mode_i,
  // Configuration and status
  output logic [1:0]              data_width_o,
  output logic [1:0]              parity_mode_o,
  output logic [1:0]              stop_bits_o,
  output logic [1:0]              comm_mode_o,
  output logic                    cfg_store_o,
  output logic                    config_done_o,
  output logic                    config_error_o,
  output logic                    parity_error_o,
  output logic                    tx_enable_o,
  output logic                    rx_enable_o
);

  logic timer_run;
  logic attempt_inc;
  logic attempt_clr;
  logic timeout;
  logic attempts_spent;

  // ------------------------------------------------------------------------
  // Configuration FSM and its timer
  // ------------------------------------------------------------------------

  cfg_fsm u_cfg_fsm (
    .clk_i                (clk_i),
    .rst_n_i              (rst_n_i),
    .rx_valid_i           (rx_valid_i),
    .rx_word_i            (rx_word_i),
    .rx_read_o            (rx_read_o),
    .tx_done_i            (tx_done_i),
    .tx_write_o           (tx_write_o),
    .tx_data_o            (tx_data_o),
    .cpu_rx_read_i        (cpu_rx_read_i),
    .cpu_tx_write_i       (cpu_tx_write_i),
    .cpu_tx_data_i        (cpu_tx_data_i),
    .cfg_req_mst_i        (cfg_req_mst_i),
    .cfg_req_slv_i        (cfg_req_slv_i),
    .enable_cfg_receive_i (enable_cfg_receive_i),
    .set_std_config_i     (set_std_config_i),
    .data_width_i         (data_width_i),
    .parity_mode_i        (parity_mode_i),
    .stop_bits_i          (stop_bits_i),
    .comm_mode_i          (comm_mode_i),
    .data_width_o         (data_width_o),
    .parity_mode_o        (parity_mode_o),
    .stop_bits_o          (stop_bits_o),
    .comm_mode_o          (comm_mode_o),
    .cfg_store_o          (cfg_store_o),
    .config_done_o        (config_done_o),
    .config_error_o       (config_error_o),
    .timeout_i            (timeout),
    .attempts_spent_i     (attempts_spent),
    .timer_run_o          (timer_run),
    .attempt_inc_o        (attempt_inc),
    .attempt_clr_o        (attempt_clr)
  );

  cfg_timer #(
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
  ) u_cfg_timer (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .timer_run_i      (timer_run),
    .attempt_inc_i    (attempt_inc),
    .attempt_clr_i    (attempt_clr),
    .timeout_o        (timeout),
    .attempts_spent_o (attempts_spent)
  );

  // Parity uses the configuration currently applied by the CPU
  parity_checker u_parity_checker (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .rx_word_i      (rx_word_i),
    .parity_bit_i   (parity_bit_i),
    .data_width_i   (data_width_i),
    .parity_mode_i  (parity_mode_i),
    .parity_error_o (parity_error_o)
  );

  // Bit 0 of the communication mode enables the transmitter, bit 1 the receiver
  assign tx_enable_o = comm_mode_i[0];
  assign rx_enable_o = comm_mode_i[1];

endmodule

// File: dv/uart_ctrl_sva.sv
// ------------------------------------------------------------------------
// Concurrent assertions on the UART controller top level, bound into
// every instance of it
// ------------------------------------------------------------------------

`timescale 1ns/10ps

module uart_ctrl_sva (
  input logic clk_i,
  input logic rst_n_i,
  input logic tx_write_o,
  input logic rx_read_o,
  input logic cfg_store_o,
  input logic config_done_o,
  input logic config_error_o,
  input logic parity_error_o
);

  // The cycle after a reset edge sees MAIN with no pulses
  assert property (@(posedge clk_i)
    !rst_n_i |=> !cfg_store_o && !config_error_o && !parity_error_o && config_done_o)
    else $error("Controls not quiet after reset");

  // An error pulse never stretches
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    parity_error_o |=> !parity_error_o)
    else $error("parity_error_o high for more than one cycle");

  // A failed configuration always falls back to the standard setting
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    config_error_o |=> cfg_store_o)
    else $error("config_error_o not followed by cfg_store_o");

  // The FSM owns both FIFOs during configuration and never pushes and pops together
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !config_done_o |-> !(tx_write_o && rx_read_o))
    else $error("tx_write_o and rx_read_o high together during configuration");

endmodule

bind uart_ctrl_top uart_ctrl_sva u_uart_ctrl_sva (.*);

// File: dv/tb_uart_ctrl.sv
// ------------------------------------------------------------------------
// Testbench of the UART configuration controller: clock and reset, a
// peer model for master and slave exchanges, a parity model, compare
// tasks and a cycle watchdog
// ------------------------------------------------------------------------

`timescale 1ns/10ps

module tb_uart_ctrl;

  import uart_ctrl_pkg::*;

  localparam logic [31:0] TIMEOUT_CYCLES = 32'd40;
  localparam int          CYCLE_LIMIT    = 20000;
  localparam int          PARITY_WORDS   = 200;

  logic       clk_i;
  logic       rst_n_i;
  logic       rx_valid_i;
  rx_word_u   rx_word_i;
  logic       parity_bit_i;
  logic       rx_read_o;
  logic       tx_done_i;
  logic       tx_write_o;
  logic [7:0] tx_data_o;
  logic       cpu_rx_read_i;
  logic       cpu_tx_write_i;
  logic [7:0] cpu_tx_data_i;
  logic       cfg_req_mst_i;
  logic       cfg_req_slv_i;
  logic       enable_cfg_receive_i;
  logic       set_std_config_i;
  logic [1:0] data_width_i;
  logic [1:0] parity_mode_i;
  logic [1:0] stop_bits_i;
  logic [1:0] comm_mode_i;
  logic [1:0] data_width_o;
  logic [1:0] parity_mode_o;
  logic [1:0] stop_bits_o;
  logic [1:0] comm_mode_o;
  logic       cfg_store_o;
  logic       config_done_o;
  logic       config_error_o;
  logic       parity_error_o;
  logic       tx_enable_o;
  logic       rx_enable_o;

  integer     seed;
  int         cycle_cnt = 0;

  uart_ctrl_top #(
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
  ) dut_i (.*);

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  // ------------------------------------------------------------------------
  // Run control and compare tasks
  // ------------------------------------------------------------------------

  task automatic abort_run;
    $display("tests failed");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  // The longest test takes a few hundred cycles, so the limit is generous
  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("The run hung and reached the cycle limit of %0d", CYCLE_LIMIT);
      abort_run;
    end
  end

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
      abort_run;
    end
  endtask

  task automatic check_cfg(input string name, input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp) begin
      $display("ERROR %s: expected %b, actual %b", name, exp, act);
      abort_run;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR %s: expected %b, actual %b", name, exp, act);
      abort_run;
    end
  endtask

  task automatic compare_config_outputs(input string name, input logic [1:0] dw,
                                        input logic [1:0] pm, input logic [1:0] sb,
                                        input logic [1:0] cm);
    check_cfg({name, " data width"}, dw, data_width_o);
    check_cfg({name, " parity mode"}, pm, parity_mode_o);
    check_cfg({name, " stop bits"}, sb, stop_bits_o);
    check_cfg({name, " comm mode"}, cm, comm_mode_o);
  endtask

  // Inputs change 10 ns after the edge and strobes fall back to low
  task automatic tick;
    @(posedge clk_i);
    #10;
    tx_done_i            = 1'b0;
    rx_valid_i           = 1'b0;
    cfg_req_mst_i        = 1'b0;
    cfg_req_slv_i        = 1'b0;
    enable_cfg_receive_i = 1'b0;
    set_std_config_i     = 1'b0;
  endtask

  // Outputs are compared in the middle of the cycle
  task automatic sample;
    @(negedge clk_i);
  endtask

  task automatic randomize_config;
    logic [31:0] rnd;
    rnd           = $random(seed);
    data_width_i  = rnd[1:0];
    parity_mode_i = rnd[3:2];
    stop_bits_i   = rnd[5:4];
    comm_mode_i   = rnd[7:6];
  endtask

  // ------------------------------------------------------------------------
  // Peer model
  // ------------------------------------------------------------------------

  // The transmitter reports a written byte as sent 1 to 5 cycles later
  task automatic transmit_delay(input string name);
    int gap;
    gap = 1 + {$random(seed)} % 5;
    for (int i = 1; i <= gap; i++) begin
      tick;
      tx_done_i = (i == gap);
      sample;
      check_bit({name, " write while busy"}, 1'b0, tx_write_o);
    end
  endtask

  // The peer answers after a short random pause, far below the timeout
  task automatic idle_wait(input string name);
    int gap;
    gap = {$random(seed)} % 4;
    repeat (gap) begin
      tick;
      sample;
      check_bit({name, " idle write"}, 1'b0, tx_write_o);
      check_bit({name, " idle store"}, 1'b0, cfg_store_o);
    end
  endtask

  task automatic send_ackn(input string name);
    tick;
    rx_valid_i    = 1'b1;
    rx_word_i.raw = ACKN_CHAR;
    sample;
    check_bit({name, " ackn pop"}, 1'b1, rx_read_o);
  endtask

  // Checks the SYN already on the bus and the rest of the burst
  task automatic expect_syn_burst(input string name);
    check_bit({name, " syn write"}, 1'b1, tx_write_o);
    check_byte({name, " syn char"}, SYN_CHAR, tx_data_o);
    repeat (SYN_COUNT - 2'd1) begin
      tick;
      sample;
      check_bit({name, " syn write"}, 1'b1, tx_write_o);
      check_byte({name, " syn char"}, SYN_CHAR, tx_data_o);
    end
  endtask

  // Even parity makes the count of ones including the parity bit even
  function automatic logic model_mismatch(input logic [7:0] word, input logic pbit,
                                          input logic [1:0] width, input logic [1:0] mode);
    int   ones;
    logic expected;
    ones = 0;
    for (int i = 0; i < 5 + width; i++) begin
      ones += word[i];
    end
    expected = ones[0];
    if (mode == PM_ODD) begin
      expected = !expected;
    end
    return (mode == PM_EVEN || mode == PM_ODD) && (pbit != expected);
  endfunction

  // ------------------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------------------

  task automatic verify_reset_state;
    sample;
    check_bit("reset tx_write", 1'b0, tx_write_o);
    check_bit("reset rx_read", 1'b0, rx_read_o);
    check_bit("reset cfg_store", 1'b0, cfg_store_o);
    check_bit("reset config_error", 1'b0, config_error_o);
    check_bit("reset parity_error", 1'b0, parity_error_o);
    check_bit("reset config_done", 1'b1, config_done_o);
    check_bit("reset tx_enable", comm_mode_i[0], tx_enable_o);
    check_bit("reset rx_enable", comm_mode_i[1], rx_enable_o);
  endtask

  // In MAIN the CPU strobes and byte pass straight to the FIFOs
  task automatic check_cpu_passthrough;
    logic [31:0] rnd;
    repeat (8) begin
      tick;
      rnd            = $random(seed);
      cpu_rx_read_i  = rnd[0];
      cpu_tx_write_i = rnd[1];
      comm_mode_i    = rnd[3:2];
      cpu_tx_data_i  = rnd[15:8];
      sample;
      check_bit("cpu rx_read", rnd[0], rx_read_o);
      check_bit("cpu tx_write", rnd[1], tx_write_o);
      check_byte("cpu tx_data", rnd[15:8], tx_data_o);
      check_bit("cpu tx_enable", rnd[2], tx_enable_o);
      check_bit("cpu rx_enable", rnd[3], rx_enable_o);
    end
    tick;
    cpu_rx_read_i  = 1'b0;
    cpu_tx_write_i = 1'b0;
  endtask

  task automatic apply_std_config;
    tick;
    randomize_config;
    set_std_config_i = 1'b1;
    sample;
    check_bit("std_config early store", 1'b0, cfg_store_o);
    tick;
    sample;
    check_bit("std_config store", 1'b1, cfg_store_o);
    check_bit("std_config busy", 1'b0, config_done_o);
    compare_config_outputs("std_config", STD_DATA_WIDTH, STD_PARITY_MODE,
                           STD_STOP_BITS, STD_COMM_MODE);
    tick;
    sample;
    check_bit("std_config done", 1'b1, config_done_o);
    check_bit("std_config single store", 1'b0, cfg_store_o);
  endtask

  task automatic configure_as_slave;
    int          n_pkt;
    logic [31:0] rnd;
    logic [1:0]  exp_dw;
    logic [1:0]  exp_pm;
    logic [1:0]  exp_sb;
    n_pkt = 3 + {$random(seed)} % 3;
    tick;
    randomize_config;
    cfg_req_slv_i        = 1'b1;
    enable_cfg_receive_i = 1'b1;
    sample;
    check_bit("slave request cycle", 1'b0, tx_write_o);
    tick;
    sample;
    check_bit("slave request ackn write", 1'b1, tx_write_o);
    check_byte("slave request ackn", ACKN_CHAR, tx_data_o);
    transmit_delay("slave");
    for (int p = 0; p <= n_pkt; p++) begin
      idle_wait("slave");
      tick;
      rnd                     = $random(seed);
      exp_dw                  = data_width_i;
      exp_pm                  = parity_mode_i;
      exp_sb                  = stop_bits_i;
      rx_valid_i              = 1'b1;
      rx_word_i.packet.option = rnd[1:0];
      // Field order is random and the last packet closes the exchange
      if (p == n_pkt) begin
        rx_word_i.packet.id = END_CONFIG_ID;
      end else if (rnd[7:2] % 3 == 0) begin
        rx_word_i.packet.id = DATA_WIDTH_ID;
        exp_dw              = rnd[1:0];
      end else if (rnd[7:2] % 3 == 1) begin
        rx_word_i.packet.id = PARITY_MODE_ID;
        exp_pm              = rnd[1:0];
      end else begin
        rx_word_i.packet.id = STOP_BITS_ID;
        exp_sb              = rnd[1:0];
      end
      sample;
      check_bit("slave packet pop", 1'b1, rx_read_o);
      check_bit("slave packet store", p != n_pkt, cfg_store_o);
      compare_config_outputs("slave packet", exp_dw, exp_pm, exp_sb, comm_mode_i);
      tick;
      sample;
      check_bit("slave packet ackn write", 1'b1, tx_write_o);
      check_byte("slave packet ackn", ACKN_CHAR, tx_data_o);
      transmit_delay("slave");
    end
    tick;
    sample;
    check_bit("slave done", 1'b1, config_done_o);
  endtask

  task automatic configure_as_master;
    logic [7:0]  exp_pkt [4];
    logic [31:0] rnd;
    tick;
    randomize_config;
    exp_pkt[0]    = {DATA_WIDTH_ID, data_width_i};
    exp_pkt[1]    = {PARITY_MODE_ID, parity_mode_i};
    exp_pkt[2]    = {STOP_BITS_ID, stop_bits_i};
    exp_pkt[3]    = {END_CONFIG_ID, 2'b00};
    cfg_req_mst_i = 1'b1;
    sample;
    tick;
    sample;
    expect_syn_burst("master");
    // A stray word before the acknowledgement is popped and dropped
    tick;
    rnd           = $random(seed);
    rx_valid_i    = 1'b1;
    rx_word_i.raw = rnd[7:0];
    if (rx_word_i.raw == ACKN_CHAR) begin
      rx_word_i.raw = SYN_CHAR;
    end
    sample;
    check_bit("master stray pop", 1'b1, rx_read_o);
    idle_wait("master");
    send_ackn("master request");
    for (int p = 0; p < 4; p++) begin
      tick;
      sample;
      check_bit("master packet write", 1'b1, tx_write_o);
      check_byte("master packet", exp_pkt[p], tx_data_o);
      transmit_delay("master");
      idle_wait("master");
      send_ackn("master packet");
    end
    tick;
    sample;
    check_bit("master done", 1'b1, config_done_o);
  endtask

  task automatic master_timeout_sequence;
    int waited;
    tick;
    randomize_config;
    cfg_req_mst_i = 1'b1;
    sample;
    tick;
    sample;
    for (int burst = 1; burst <= MAX_ATTEMPTS; burst++) begin
      expect_syn_burst("master_timeout");
      waited = 0;
      do begin
        tick;
        sample;
        waited++;
        if (waited > 2 * TIMEOUT_CYCLES) begin
          $display("Master timeout: no new burst and no error after %0d cycles", waited);
          abort_run;
        end
      end while (!tx_write_o && !config_error_o);
      check_bit("master_timeout error", burst == MAX_ATTEMPTS, config_error_o);
    end
    tick;
    sample;
    check_bit("master_timeout store", 1'b1, cfg_store_o);
    check_bit("master_timeout single error", 1'b0, config_error_o);
    compare_config_outputs("master_timeout", STD_DATA_WIDTH, STD_PARITY_MODE,
                           STD_STOP_BITS, STD_COMM_MODE);
    tick;
    sample;
    check_bit("master_timeout done", 1'b1, config_done_o);
  endtask

  task automatic parity_sweep;
    logic [31:0] rnd;
    logic        mism_now;
    logic        mism_prev;
    logic        mism_prev2;
    // Two clean cycles give the model a known history
    tick;
    rx_word_i.raw = 8'h00;
    parity_bit_i  = 1'b0;
    parity_mode_i = PM_EVEN;
    data_width_i  = DW_8BIT;
    sample;
    tick;
    sample;
    mism_prev  = 1'b0;
    mism_prev2 = 1'b0;
    repeat (PARITY_WORDS) begin
      tick;
      rnd           = $random(seed);
      rx_word_i.raw = rnd[7:0];
      parity_bit_i  = rnd[8];
      data_width_i  = rnd[10:9];
      parity_mode_i = rnd[12:11];
      mism_now      = model_mismatch(rnd[7:0], rnd[8], rnd[10:9], rnd[12:11]);
      sample;
      check_bit("parity", mism_prev && !mism_prev2, parity_error_o);
      mism_prev2 = mism_prev;
      mism_prev  = mism_now;
    end
  endtask

  initial begin
    seed                 = 32'ha530;
    rst_n_i              = 1'b0;
    rx_valid_i           = 1'b0;
    rx_word_i            = '0;
    parity_bit_i         = 1'b0;
    tx_done_i            = 1'b0;
    cpu_rx_read_i        = 1'b0;
    cpu_tx_write_i       = 1'b0;
    cpu_tx_data_i        = 8'h00;
    cfg_req_mst_i        = 1'b0;
    cfg_req_slv_i        = 1'b0;
    enable_cfg_receive_i = 1'b0;
    set_std_config_i     = 1'b0;
    data_width_i         = DW_8BIT;
    parity_mode_i        = PM_EVEN;
    stop_bits_i          = 2'b00;
    comm_mode_i          = 2'b00;
    repeat (16) @(posedge clk_i);
    #10;
    rst_n_i = 1'b1;
    verify_reset_state;
    check_cpu_passthrough;
    apply_std_config;
    configure_as_slave;
    configure_as_master;
    master_timeout_sequence;
    parity_sweep;
    $display("all tests passed");
    $finish;
  end

endmodule

// File: build.f
common/uart_ctrl_pkg.sv
rtl/parity_checker.sv
cfg/cfg_timer.sv
cfg/cfg_fsm.sv
rtl/uart_ctrl_top.sv
dv/uart_ctrl_sva.sv
dv/tb_uart_ctrl.sv

// File: Bender.yml
package:
  name: uart_ctrl

sources:
  # Design
  - files:
      - common/uart_ctrl_pkg.sv
      - rtl/parity_checker.sv
      - cfg/cfg_timer.sv
      - cfg/cfg_fsm.sv
      - rtl/uart_ctrl_top.sv

  # Testbench and bound assertions
  - target: test
    files:
      - dv/uart_ctrl_sva.sv
      - dv/tb_uart_ctrl.sv
